/* sim/pipeCases.txt */
# test <name> | prog <byte address hex> <instruction hex> | check <register> <expected hex>
# Producers sit three or more instructions ahead of their consumers
test alu
prog 00 20010007
prog 04 2002FFFD
prog 08 20000005
prog 0C 00000000
prog 10 00221820
prog 14 00222022
prog 18 00222824
prog 1C 00223025
prog 20 0041382A
prog 24 FC000000
check 0 00000000
check 1 00000007
check 2 FFFFFFFD
check 3 00000004
check 4 0000000A
check 5 00000005
check 6 FFFFFFFF
check 7 00000001
test mem
prog 00 20010055
prog 04 2002FFFF
prog 08 00000000
prog 0C AC010008
prog 10 AC02000C
prog 14 8C030008
prog 18 8C04000C
prog 1C FC000000
check 3 00000055
check 4 FFFFFFFF
test branch
prog 00 20010001
prog 04 20020001
prog 08 00000000
prog 0C 00000000
prog 10 10220004
prog 14 20030003
prog 18 20040004
prog 1C 20050005
prog 20 20060006
prog 24 10010004
prog 28 20070007
prog 2C FC000000
prog 30 20080008
check 3 00000003
check 4 00000004
check 5 00000005
check 6 00000000
check 7 00000007
check 8 00000000

/* list.f */
logic/isaPkg.sv
logic/pipePkg.sv
logic/stageIf.sv
logic/fetchStage.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpuTop.sv
sim/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/cpuTb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

  localparam int IMEM_DEPTH   = 64;
  localparam int DMEM_DEPTH   = 64;
  localparam int HALT_TIMEOUT = 500; // Cycles allowed from run to halted

  logic          Clk;
  logic          rstN;
  logic          run;
  logic          imemWe;
  isaPkg::word   imemAddr;
  isaPkg::word   imemData;
  isaPkg::regIdx dbgIdx;
  isaPkg::word   dbgData;
  logic          halted;

  // Test being collected from the cases file
  string         testName;
  isaPkg::word   progAddr [$];
  isaPkg::word   progWord [$];
  isaPkg::regIdx chkReg [$];
  isaPkg::word   chkVal [$];

  int testCount;
  int testFails;
  int checkCount;
  int errCount;
  int testErrs;   // Errors of the running test only

  cpuTop #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) DUT (
    .Clk(Clk), .rstN(rstN), .run(run),
    .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
    .dbgIdx(dbgIdx), .dbgData(dbgData), .halted(halted)
  );

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  task automatic compareWord(input string what, input isaPkg::word expected,
                             input isaPkg::word actual);
    checkCount++;
    if (actual !== expected) begin
      $display("ERR %s: %s expected %h actual %h", testName, what, expected, actual);
      testErrs++;
    end
  endtask

  task automatic compareFlag(input string what, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      $display("ERR %s: %s expected %b actual %b", testName, what, expected, actual);
      testErrs++;
    end
  endtask

  // Core idle and held in reset for 10 cycles
  task automatic resetDut();
    @(negedge Clk);
    rstN   = 1'b0;
    run    = 1'b0;
    imemWe = 1'b0;
    repeat (10) @(negedge Clk);
    rstN = 1'b1;
  endtask

  task automatic loadProgram();
    foreach (progAddr[i]) begin
      @(negedge Clk);
      imemWe   = 1'b1;
      imemAddr = progAddr[i]; // Byte address
      imemData = progWord[i];
    end
    @(negedge Clk);
    imemWe = 1'b0;
    @(negedge Clk);
    run = 1'b1;               // Load port is quiet from here on
  endtask

  task automatic waitHalted(output bit done);
    int cycles;
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT) begin
      @(negedge Clk);
      cycles++;
    end
    done = halted;
  endtask

  // Debug port is combinational, sampled one falling edge later
  task automatic readReg(input isaPkg::regIdx idx, output isaPkg::word value);
    @(negedge Clk);
    dbgIdx = idx;
    @(negedge Clk);
    value = dbgData;
  endtask

  task automatic runTest();
    bit          done;
    isaPkg::word value;
    testErrs = 0;
    testCount++;
    resetDut();
    compareFlag("halted after reset", 1'b0, halted);
    loadProgram();
    waitHalted(done);
    if (!done) begin
      $display("%s: core did not raise halted within %0d cycles", testName, HALT_TIMEOUT);
      testErrs++;
    end else begin
      foreach (chkReg[i]) begin
        readReg(chkReg[i], value);
        compareWord($sformatf("r%0d", chkReg[i]), chkVal[i], value);
      end
      compareFlag("halted still high", 1'b1, halted); // Sticky until reset
    end
    errCount += testErrs;
    if (testErrs == 0) begin
      $display("%s: ok", testName);
    end else begin
      $display("%s: %0d errors", testName, testErrs);
      testFails++;
    end
    progAddr.delete();
    progWord.delete();
    chkReg.delete();
    chkVal.delete();
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    string       tag;
    string       name;
    isaPkg::word a;
    isaPkg::word b;
    rstN     = 1'b0;
    run      = 1'b0;
    imemWe   = 1'b0;
    imemAddr = '0;
    imemData = '0;
    dbgIdx   = '0;
    testName = "";
    testCount = 0;
    testFails = 0;
    checkCount = 0;
    errCount = 0;
    fd = $fopen("sim/pipeCases.txt", "r");
    if (fd == 0) $display("could not open the cases file sim/pipeCases.txt");
    while (fd != 0 && !$feof(fd)) begin
      line = "";
      tag  = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%s", tag);
      if (tag == "test") begin
        if (testName != "") runTest(); // Previous test is complete
        n = $sscanf(line, "%s %s", tag, name);
        testName = name;
      end else if (tag == "prog") begin
        n = $sscanf(line, "%s %h %h", tag, a, b);
        progAddr.push_back(a);
        progWord.push_back(b);
      end else if (tag == "check") begin
        n = $sscanf(line, "%s %d %h", tag, a, b);
        chkReg.push_back(a[4:0]);
        chkVal.push_back(b);
      end
    end
    if (fd != 0) $fclose(fd);
    if (testName != "") runTest();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, testFails, checkCount, errCount);
    if (errCount == 0 && testCount > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/cpuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTop #(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  wire logic     Clk,
  input  wire logic     rstN,
  input  wire logic     run,
  input  wire logic     imemWe,
  input  isaPkg::word   imemAddr,
  input  isaPkg::word   imemData,
  input  isaPkg::regIdx dbgIdx,
  output isaPkg::word   dbgData,
  output logic          halted
);

  isaPkg::word pc4;
  isaPkg::word instr;
  logic        valid;
  logic        stop;
  logic        redirect;
  isaPkg::word redirectPc;

  idExIf  idEx ();
  exMemIf exMem ();
  memWbIf memWb ();

  fetchStage #(.IMEM_DEPTH(IMEM_DEPTH)) uFetch (
    .Clk(Clk), .rstN(rstN), .run(run), .stop(stop),
    .redirect(redirect), .redirectPc(redirectPc),
    .imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
    .pc4(pc4), .instr(instr), .valid(valid)
  );

  decodeStage uDecode (
    .Clk(Clk), .rstN(rstN), .pc4(pc4), .instr(instr), .valid(valid),
    .stop(stop), .dbgIdx(dbgIdx), .dbgData(dbgData),
    .idEx(idEx.source), .memWb(memWb.sink)
  );

  executeStage uExecute (.Clk(Clk), .rstN(rstN), .idEx(idEx.sink), .exMem(exMem.source));

  memoryStage #(.DMEM_DEPTH(DMEM_DEPTH)) uMemory (
    .Clk(Clk), .rstN(rstN), .redirect(redirect), .redirectPc(redirectPc),
    .exMem(exMem.sink), .memWb(memWb.source)
  );

  // Sticky until reset, set once the halt leaves MEM/WB
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN)           halted <= 1'b0;
    else if (memWb.halt) halted <= 1'b1;
  end

endmodule

`default_nettype wire

/* logic/memoryStage.sv */
`timescale 1ns/1ns
`default_nettype none

module memoryStage #(
  parameter int DMEM_DEPTH = 64
) (
  input  wire logic Clk,
  input  wire logic rstN,
  output logic      redirect,
  output isaPkg::word redirectPc,
  exMemIf.sink      exMem,
  memWbIf.source    memWb
);

  localparam int DMEM_AW = $clog2(DMEM_DEPTH);

  isaPkg::word               dmem [DMEM_DEPTH];
  logic        [DMEM_AW-1:0] dAddr;
  isaPkg::word               rdData;
  logic                      wbMemToReg;
  isaPkg::word               wbLoadData;
  isaPkg::word               wbAluResult;

  assign dAddr  = exMem.aluResult[DMEM_AW+1:2]; // Word index from byte address
  assign rdData = exMem.ctrl.memRead ? dmem[dAddr] : '0;

  always_ff @(posedge Clk) begin
    if (exMem.ctrl.memWrite) dmem[dAddr] <= exMem.storeData;
  end

  // Branch decision, PC picks it up at the next edge
  assign redirect   = exMem.ctrl.branch & exMem.zero;
  assign redirectPc = exMem.branchTarget;

  // MEM/WB register
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      memWb.regWrite <= 1'b0;
      memWb.halt     <= 1'b0;
      wbMemToReg     <= 1'b0;
    end else begin
      memWb.regWrite <= exMem.ctrl.regWrite;
      memWb.halt     <= exMem.ctrl.halt;
      wbMemToReg     <= exMem.ctrl.memToReg;
    end
  end

  always_ff @(posedge Clk) begin
    memWb.writeReg <= exMem.writeReg;
    wbLoadData     <= rdData;
    wbAluResult    <= exMem.aluResult;
  end

  assign memWb.writeData = wbMemToReg ? wbLoadData : wbAluResult; // Writeback mux

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage (
  input  wire logic Clk,
  input  wire logic rstN,
  idExIf.sink       idEx,
  exMemIf.source    exMem
);

  isaPkg::word   opB;
  isaPkg::word   aluOut;
  isaPkg::regIdx dstIdx;
  isaPkg::word   target;

  assign opB    = idEx.ctrl.aluSrc ? idEx.imm : idEx.rtData;   // Immediate or rt
  assign dstIdx = idEx.ctrl.regDst ? idEx.rdIdx : idEx.rtIdx; // rd for R-type
  assign target = idEx.pc4 + (idEx.imm << 2);                 // Word offset

  // ALU
  always_comb begin
    case (idEx.ctrl.aluOp)
      pipePkg::aluAdd: aluOut = idEx.rsData + opB;
      pipePkg::aluSub: aluOut = idEx.rsData - opB;
      pipePkg::aluAnd: aluOut = idEx.rsData & opB;
      pipePkg::aluOr:  aluOut = idEx.rsData | opB;
      pipePkg::aluSlt: aluOut = {31'd0, $signed(idEx.rsData) < $signed(opB)};
      default:         aluOut = '0;
    endcase
  end

  // EX/MEM register, control part
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) exMem.ctrl <= pipePkg::CTRL_BUBBLE;
    else       exMem.ctrl <= idEx.ctrl;
  end

  // EX/MEM register, payload part
  always_ff @(posedge Clk) begin
    exMem.aluResult    <= aluOut;
    exMem.zero         <= (aluOut == '0);
    exMem.storeData    <= idEx.rtData; // sw data comes from rt
    exMem.branchTarget <= target;
    exMem.writeReg     <= dstIdx;
  end

  // Decode must never hand over a writing op with a stray ALU code
  aAluOpDefined : assert property (@(posedge Clk) disable iff (!rstN)
    idEx.ctrl.regWrite |-> idEx.ctrl.aluOp inside {pipePkg::aluAdd, pipePkg::aluSub,
      pipePkg::aluAnd, pipePkg::aluOr, pipePkg::aluSlt});

endmodule

`default_nettype wire

/* logic/decodeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
  input  wire logic     Clk,
  input  wire logic     rstN,
  input  isaPkg::word   pc4,
  input  isaPkg::word   instr,
  input  wire logic     valid,
  output logic          stop,
  input  isaPkg::regIdx dbgIdx,
  output isaPkg::word   dbgData,
  idExIf.source         idEx,
  memWbIf.sink          memWb
);

  isaPkg::opcodeE opcode;
  isaPkg::functE  funct;
  isaPkg::regIdx  rsIdx;
  isaPkg::regIdx  rtIdx;
  isaPkg::regIdx  rdIdx;
  isaPkg::word    immExt;
  isaPkg::word    rsData;
  isaPkg::word    rtData;
  pipePkg::ctrlS  ctrl;
  logic           haltSeen;

  // Field split
  assign opcode = isaPkg::opcodeE'(instr[isaPkg::WORD_W-1 -: isaPkg::OPCODE_W]);
  assign funct  = isaPkg::functE'(instr[isaPkg::FUNCT_W-1:0]);
  assign rsIdx  = instr[25 -: isaPkg::REG_W];
  assign rtIdx  = instr[20 -: isaPkg::REG_W];
  assign rdIdx  = instr[15 -: isaPkg::REG_W];
  assign immExt = {{(isaPkg::WORD_W-isaPkg::IMM_W){instr[isaPkg::IMM_W-1]}},
                   instr[isaPkg::IMM_W-1:0]};

  registerFile uRegs (
    .Clk(Clk), .rstN(rstN),
    .we(memWb.regWrite), .wIdx(memWb.writeReg), .wData(memWb.writeData),
    .rsIdx(rsIdx), .rsData(rsData), .rtIdx(rtIdx), .rtData(rtData),
    .dbgIdx(dbgIdx), .dbgData(dbgData)
  );

  // Controller
  always_comb begin
    ctrl = pipePkg::CTRL_BUBBLE; // Unknown encodings fall out as bubbles
    if (valid) begin
      case (opcode)
        isaPkg::opRType: begin
          ctrl.regDst   = 1'b1;
          ctrl.regWrite = 1'b1;
          case (funct)
            isaPkg::fnAdd: ctrl.aluOp = pipePkg::aluAdd;
            isaPkg::fnSub: ctrl.aluOp = pipePkg::aluSub;
            isaPkg::fnAnd: ctrl.aluOp = pipePkg::aluAnd;
            isaPkg::fnOr:  ctrl.aluOp = pipePkg::aluOr;
            isaPkg::fnSlt: ctrl.aluOp = pipePkg::aluSlt;
            default:       ctrl = pipePkg::CTRL_BUBBLE;
          endcase
        end
        isaPkg::opAddi: {ctrl.aluSrc, ctrl.regWrite} = 2'b11;
        isaPkg::opLw:   {ctrl.aluSrc, ctrl.memRead, ctrl.memToReg, ctrl.regWrite} = 4'hF;
        isaPkg::opSw:   {ctrl.aluSrc, ctrl.memWrite} = 2'b11;
        isaPkg::opBeq: begin
          ctrl.branch = 1'b1;
          ctrl.aluOp  = pipePkg::aluSub; // Zero flag means equal
        end
        isaPkg::opHalt: ctrl.halt = 1'b1;
        default: ;
      endcase
    end
  end

  // Sticky halt so fetch stays frozen after the halt moves on
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN)          haltSeen <= 1'b0;
    else if (ctrl.halt) haltSeen <= 1'b1;
  end
  assign stop = haltSeen | ctrl.halt;

  // ID/EX register, control part
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) idEx.ctrl <= pipePkg::CTRL_BUBBLE;
    else       idEx.ctrl <= ctrl;
  end

  // ID/EX register, payload part
  always_ff @(posedge Clk) begin
    idEx.rsData <= rsData;
    idEx.rtData <= rtData;
    idEx.imm    <= immExt;
    idEx.pc4    <= pc4;
    idEx.rtIdx  <= rtIdx;
    idEx.rdIdx  <= rdIdx;
  end

endmodule

`default_nettype wire

/* logic/registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile (
  input  wire logic    Clk,
  input  wire logic    rstN,
  input  wire logic    we,
  input  isaPkg::regIdx wIdx,
  input  isaPkg::word  wData,
  input  isaPkg::regIdx rsIdx,
  output isaPkg::word  rsData,
  input  isaPkg::regIdx rtIdx,
  output isaPkg::word  rtData,
  input  isaPkg::regIdx dbgIdx,
  output isaPkg::word  dbgData
);

  isaPkg::word regs [32];
  logic        wEn;

  assign wEn = we && (wIdx != '0); // r0 is never written

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (wEn) begin
      regs[wIdx] <= wData;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  assign rsData  = (wEn && wIdx == rsIdx) ? wData : regs[rsIdx];
  assign rtData  = (wEn && wIdx == rtIdx) ? wData : regs[rtIdx];
  assign dbgData = regs[dbgIdx];

  // r0 stays zero through every write from writeback
  aZeroReg : assert property (@(posedge Clk) disable iff (!rstN)
    (rsIdx != '0 || rsData == '0) && (rtIdx != '0 || rtData == '0) &&
    (dbgIdx != '0 || dbgData == '0));

endmodule

`default_nettype wire

/* logic/fetchStage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchStage #(
  parameter int IMEM_DEPTH = 64
) (
  input  wire logic        Clk,
  input  wire logic        rstN,
  input  wire logic        run,
  input  wire logic        stop,       // Halt seen in decode
  input  wire logic        redirect,   // Taken beq in EX/MEM
  input  isaPkg::word      redirectPc,
  input  wire logic        imemWe,
  input  isaPkg::word      imemAddr,   // Byte address
  input  isaPkg::word      imemData,
  output isaPkg::word      pc4,
  output isaPkg::word      instr,
  output logic             valid
);

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  isaPkg::word imem [IMEM_DEPTH];
  isaPkg::word pc;
  isaPkg::word pcPlus4;

  assign pcPlus4 = pc + 32'd4;

  // Host load port, word aligned
  always_ff @(posedge Clk) begin
    if (imemWe) imem[imemAddr[IMEM_AW+1:2]] <= imemData;
  end

  // PC and IF/ID register
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      pc    <= '0;
      pc4   <= '0;
      instr <= '0;
      valid <= 1'b0;
    end else if (run && !stop) begin
      pc4   <= pcPlus4;
      instr <= imem[pc[IMEM_AW+1:2]];
      valid <= 1'b1;
      pc    <= redirect ? redirectPc : pcPlus4; // Branch resolved in MEM
    end else begin
      instr <= '0;   // Bubble, PC holds
      valid <= 1'b0;
    end
  end

  // Host must finish loading before the core runs
  aLoadIdle : assert property (@(posedge Clk) disable iff (!rstN) run |-> !imemWe);

endmodule

`default_nettype wire

/* logic/stageIf.sv */
`timescale 1ns/1ns
`default_nettype none

// Decode to execute
interface idExIf;
  pipePkg::ctrlS ctrl;
  isaPkg::word   rsData;
  isaPkg::word   rtData;
  isaPkg::word   imm;    // Already sign extended
  isaPkg::word   pc4;
  isaPkg::regIdx rtIdx;
  isaPkg::regIdx rdIdx;
  modport source (output ctrl, rsData, rtData, imm, pc4, rtIdx, rdIdx);
  modport sink   (input  ctrl, rsData, rtData, imm, pc4, rtIdx, rdIdx);
endinterface

// Execute to memory
interface exMemIf;
  pipePkg::ctrlS ctrl;
  isaPkg::word   aluResult;
  logic          zero;
  isaPkg::word   storeData;
  isaPkg::word   branchTarget;
  isaPkg::regIdx writeReg;
  modport source (output ctrl, aluResult, zero, storeData, branchTarget, writeReg);
  modport sink   (input  ctrl, aluResult, zero, storeData, branchTarget, writeReg);
endinterface

// Memory to writeback, read back by decode for the register file
interface memWbIf;
  logic          regWrite;
  isaPkg::regIdx writeReg;
  isaPkg::word   writeData;
  logic          halt;
  modport source (output regWrite, writeReg, writeData, halt);
  modport sink   (input  regWrite, writeReg, writeData, halt);
endinterface

`default_nettype wire

/* logic/pipePkg.sv */
`default_nettype none

package pipePkg;

  // ALU operations selected by decode
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4  // Signed compare
  } aluOpE;

  // Control bundle that follows an instruction down the pipe
  typedef struct packed {
    logic  aluSrc;   // 1 selects the immediate as operand B
    logic  regDst;   // 1 writes rd, 0 writes rt
    logic  memRead;
    logic  memWrite;
    logic  memToReg; // 1 writes back load data
    logic  regWrite;
    logic  branch;
    logic  halt;
    aluOpE aluOp;
  } ctrlS;

  localparam ctrlS CTRL_BUBBLE = '0; // No side effects anywhere

endpackage

`default_nettype wire

/* logic/isaPkg.sv */
`default_nettype none

package isaPkg;

  // Field widths of the MIPS-style encoding
  localparam int WORD_W   = 32;
  localparam int REG_W    = 5;
  localparam int OPCODE_W = 6;
  localparam int FUNCT_W  = 6;
  localparam int IMM_W    = 16;

  typedef logic [WORD_W-1:0] word;   // Data and instruction word
  typedef logic [REG_W-1:0]  regIdx; // Register number

  // Primary opcodes, instr[31:26]
  typedef enum logic [OPCODE_W-1:0] {
    opRType = 6'h00,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2B,
    opHalt  = 6'h3F  // All ones, stops fetch
  } opcodeE;

  // R-type function codes, instr[5:0]
  typedef enum logic [FUNCT_W-1:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2A
  } functE;

endpackage

`default_nettype wire
